// File: rvfi_mon_settings.svh
`ifndef RVFI_MON_SETTINGS_SVH
`define RVFI_MON_SETTINGS_SVH

// Interrupt controller of the monitored core
// 0 means CLINT cause set and mcause layout, 1 means CLIC
`define MON_CLIC 1'b0

// Width of a CLIC interrupt id, 1 to 10
// Legal CLIC causes run from 0 to 2**width - 1
`define MON_CLIC_ID_WIDTH 5

// Width of each violation counter and of the retire counter
`define MON_CNT_WIDTH 16

`endif

// File: rvfi_pkg.sv
package rvfi_pkg;

  // Trap information of one retired instruction
  typedef struct packed {
    logic        trap;
    logic        exception;
    logic        debug;
    logic [10:0] exception_cause;
    logic        debug_cause;
    logic        rsvd;
  } trap_t;

  // First instruction of a trap handler
  typedef struct packed {
    logic        intr;
    logic        exception;
    logic        interrupt;
    logic [10:0] cause;
  } intr_t;

  typedef struct packed {
    logic        interrupt;
    logic [19:0] zero;
    logic [10:0] code;
  } mcause_clint_t;

  typedef struct packed {
    logic        interrupt;
    logic        minhv;
    logic [1:0]  mpp;
    logic        mpie;
    logic [2:0]  zero_hi;
    logic [7:0]  mpil;
    logic [4:0]  zero_lo;
    logic [10:0] code;
  } mcause_clic_t;

  // Same mcause word, decoded per interrupt controller
  typedef union packed {
    mcause_clint_t clint;
    mcause_clic_t  clic;
  } mcause_u;

  // Retirement record, one instruction per cycle
  typedef struct packed {
    logic        valid;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_rdata;
    logic [31:0] rs2_rdata;
    logic [2:0]  dbg;
    logic [31:0] dcsr_rdata;
    logic        dbg_mode;
    trap_t       trap;
    intr_t       intr;
    mcause_u     mcause_wdata;
    mcause_u     mcause_wmask;
    logic [3:0]  mem_rmask;
    logic [3:0]  mem_wmask;
    logic        is_load;
    logic        is_store;
  } retire_t;

endpackage

// File: mon_pkg.sv
package mon_pkg;

  localparam int unsigned num_rules = 8;

  typedef enum logic [2:0] {
    rs_reset,
    dbg_cause,
    exc_cause,
    exc_clears_irq,
    irq_cause_legal,
    handler_ambiguous,
    ldst_mask,
    mem_overreport
  } rule_e;

  // One bit per rule, indexed by rule_e
  typedef struct packed {
    logic                 valid;
    logic [num_rules-1:0] rule;
  } viol_t;

  typedef struct packed {
    logic        valid;
    logic        first_retire;
    logic        enter_dbg;
    logic [10:0] exc_code;
    logic        mcause_irq_wdata;
    logic        mcause_irq_wmask;
    logic [10:0] irq_cause;
    logic        irq;
    logic        irq_sync;
    logic        exception;
    logic [10:0] exc_cause;
    logic        rmask_nz;
    logic        wmask_nz;
    logic [1:0]  mem_cnt;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_rdata;
    logic [31:0] rs2_rdata;
    logic [2:0]  dbg;
    logic [2:0]  dcsr_cause;
    logic        is_load;
    logic        is_store;
    logic        trap;
  } dec_t;

  typedef struct packed {
    logic [7:0]  aw_addr;
    logic        aw_valid;
    logic [31:0] w_data;
    logic [3:0]  w_strb;
    logic        w_valid;
    logic        b_ready;
    logic [7:0]  ar_addr;
    logic        ar_valid;
    logic        r_ready;
  } axil_req_t;

  typedef struct packed {
    logic        aw_ready;
    logic        w_ready;
    logic [1:0]  b_resp;
    logic        b_valid;
    logic        ar_ready;
    logic [31:0] r_data;
    logic [1:0]  r_resp;
    logic        r_valid;
  } axil_rsp_t;

endpackage

// File: rvfi_decode.sv
`include "rvfi_mon_settings.svh"

module rvfi_decode (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  rvfi_pkg::retire_t retire,
  output mon_pkg::dec_t     dec
);

  logic          was_dbg_mode_q;
  logic          retired_q;
  mon_pkg::dec_t dec_d;
  mon_pkg::dec_t dec_q;

  // Mode history only moves on a retirement
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      was_dbg_mode_q <= 1'b0;
      retired_q      <= 1'b0;
      dec_q          <= '0;
    end else begin
      dec_q <= dec_d;
      if (retire.valid) begin
        was_dbg_mode_q <= retire.dbg_mode;
        retired_q      <= 1'b1;
      end
    end
  end

  always_comb begin
    dec_d              = '0;
    dec_d.valid        = retire.valid;
    dec_d.first_retire = !retired_q;
    dec_d.enter_dbg    = (retire.dbg != 3'd0) && !was_dbg_mode_q;
    // Interrupt bit and code read through the layout of the configured controller
    if (`MON_CLIC) begin
      dec_d.exc_code         = retire.mcause_wdata.clic.code & retire.mcause_wmask.clic.code;
      dec_d.mcause_irq_wdata = retire.mcause_wdata.clic.interrupt;
      dec_d.mcause_irq_wmask = retire.mcause_wmask.clic.interrupt;
    end else begin
      dec_d.exc_code         = retire.mcause_wdata.clint.code & retire.mcause_wmask.clint.code;
      dec_d.mcause_irq_wdata = retire.mcause_wdata.clint.interrupt;
      dec_d.mcause_irq_wmask = retire.mcause_wmask.clint.interrupt;
    end
    dec_d.irq_cause = retire.intr.cause;
    dec_d.irq       = retire.intr.interrupt;
    dec_d.irq_sync  = retire.intr.exception;
    // Exceptions in debug mode leave mcause alone
    dec_d.exception  = retire.trap.exception && !retire.dbg_mode;
    dec_d.exc_cause  = retire.trap.exception_cause;
    dec_d.rmask_nz   = |retire.mem_rmask;
    dec_d.wmask_nz   = |retire.mem_wmask;
    dec_d.mem_cnt    = {1'b0, dec_d.rmask_nz} + {1'b0, dec_d.wmask_nz};
    dec_d.rs1_addr   = retire.rs1_addr;
    dec_d.rs2_addr   = retire.rs2_addr;
    dec_d.rs1_rdata  = retire.rs1_rdata;
    dec_d.rs2_rdata  = retire.rs2_rdata;
    dec_d.dbg        = retire.dbg;
    dec_d.dcsr_cause = retire.dcsr_rdata[8:6];
    dec_d.is_load    = retire.is_load;
    dec_d.is_store   = retire.is_store;
    dec_d.trap       = retire.trap.trap;
  end

  assign dec = dec_q;

  // Only the first record after reset is seen as the first retirement
  a_first_retire_once: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    dec.valid |=> !dec.first_retire
  );

endmodule

// File: rvfi_rule_check.sv
`include "rvfi_mon_settings.svh"

module rvfi_rule_check (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  mon_pkg::dec_t  dec,
  input  logic           bus_valid,
  input  logic           bus_ready,
  output mon_pkg::viol_t viol
);

  localparam logic        clic        = `MON_CLIC;
  localparam int unsigned max_clic_id = (1 << `MON_CLIC_ID_WIDTH) - 1;
  localparam int unsigned acc_width   = 32;

  logic [acc_width-1:0]          bus_cnt_q;
  logic [acc_width-1:0]          bus_cnt_d;
  logic [acc_width-1:0]          mem_cnt_q;
  logic [acc_width-1:0]          mem_cnt_d;
  logic                          bus_hs;
  logic [mon_pkg::num_rules-1:0] rule_d;

  function automatic logic irq_cause_ok(logic [10:0] cause);
    logic clint_ok;
    logic clic_ok;
    clint_ok = cause inside {11'd3, 11'd7, 11'd11, [11'd16:11'd31], [11'd1024:11'd1027]};
    clic_ok  = (32'(cause) <= max_clic_id) || (cause inside {[11'd1024:11'd1027]});
    return clic ? clic_ok : clint_ok;
  endfunction

  // Sticks at all ones instead of wrapping
  function automatic logic [acc_width-1:0] sat_add(logic [acc_width-1:0] a, logic [1:0] b);
    logic [acc_width:0] sum;
    sum = {1'b0, a} + {{(acc_width-1){1'b0}}, b};
    return sum[acc_width] ? '1 : sum[acc_width-1:0];
  endfunction

  assign bus_hs = bus_valid && bus_ready;

  // Handshake of this cycle is already in bus_cnt_d when compared
  assign bus_cnt_d = sat_add(bus_cnt_q, {1'b0, bus_hs});
  assign mem_cnt_d = sat_add(mem_cnt_q, dec.valid ? dec.mem_cnt : 2'd0);

  always_comb begin
    rule_d = '0;
    rule_d[mon_pkg::rs_reset] = dec.first_retire &&
        (((dec.rs1_addr != 5'd0) && (dec.rs1_rdata != 32'd0)) ||
         ((dec.rs2_addr != 5'd0) && (dec.rs2_rdata != 32'd0)));
    rule_d[mon_pkg::dbg_cause] = dec.enter_dbg && (dec.dbg != dec.dcsr_cause);
    rule_d[mon_pkg::exc_cause] = dec.exception && (dec.exc_cause != dec.exc_code);
    rule_d[mon_pkg::exc_clears_irq] = dec.exception &&
        !(dec.mcause_irq_wmask && !dec.mcause_irq_wdata);
    rule_d[mon_pkg::irq_cause_legal] = dec.irq && !irq_cause_ok(dec.irq_cause);
    rule_d[mon_pkg::handler_ambiguous] = dec.irq && dec.irq_sync;
    // Masks only on loads and stores, and a load or store that did not trap has its mask
    rule_d[mon_pkg::ldst_mask] = (dec.rmask_nz && !dec.is_load) ||
                                 (dec.wmask_nz && !dec.is_store) ||
                                 (dec.is_load && !dec.trap && !dec.rmask_nz) ||
                                 (dec.is_store && !dec.trap && !dec.wmask_nz);
    rule_d[mon_pkg::mem_overreport] = mem_cnt_d > bus_cnt_d;
    if (!dec.valid) begin
      rule_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_cnt_q  <= '0;
      mem_cnt_q  <= '0;
      viol       <= '0;
    end else begin
      bus_cnt_q  <= bus_cnt_d;
      mem_cnt_q  <= mem_cnt_d;
      viol.valid <= dec.valid;
      viol.rule  <= rule_d;
    end
  end

  // Access counters only grow or hold at saturation
  a_acc_cnt_monotonic: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (bus_cnt_q >= $past(bus_cnt_q)) && (mem_cnt_q >= $past(mem_cnt_q))
  );

endmodule

// File: mon_result_regs.sv
`include "rvfi_mon_settings.svh"

module mon_result_regs (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  mon_pkg::viol_t     viol,
  input  mon_pkg::axil_req_t axil_req,
  output mon_pkg::axil_rsp_t axil_rsp
);

  localparam int unsigned cw          = `MON_CNT_WIDTH;
  localparam int unsigned nr          = mon_pkg::num_rules;
  localparam logic [1:0]  resp_okay   = 2'b00;
  localparam logic [1:0]  resp_slverr = 2'b10;

  logic [cw-1:0] cnt_q [nr];
  logic [cw-1:0] retire_cnt_q;
  logic [nr-1:0] status_q;
  logic [nr-1:0] status_clr;
  logic          clr_all;
  logic          wr_hs;
  logic          rd_hs;
  logic          wr_rdy_q;
  logic          wr_pend_q;
  logic          b_valid_q;
  logic [1:0]    b_resp_q;
  logic [7:0]    wr_addr_q;
  logic [31:0]   wr_data_q;
  logic [3:0]    wr_strb_q;
  logic          rd_rdy_q;
  logic          r_valid_q;
  logic [31:0]   r_data_q;
  logic [1:0]    r_resp_q;
  logic [31:0]   rd_data;

  function automatic logic addr_ok(logic [7:0] addr);
    return (addr[1:0] == 2'b00) && (addr <= 8'h28);
  endfunction

  assign wr_hs = axil_req.aw_valid && axil_req.w_valid && wr_rdy_q;
  assign rd_hs = axil_req.ar_valid && rd_rdy_q;

  // Write side effects take place one cycle after acceptance
  assign clr_all    = wr_pend_q && wr_strb_q[0] && (wr_addr_q == 8'h28) && wr_data_q[0];
  assign status_clr = (wr_pend_q && wr_strb_q[0] && (wr_addr_q == 8'h24)) ?
                      wr_data_q[nr-1:0] : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < nr; i++) begin
        cnt_q[i] <= '0;
      end
      retire_cnt_q <= '0;
      status_q     <= '0;
    end else begin
      // A new violation wins over a clear of the same bit
      status_q <= (status_q & ~status_clr) | viol.rule;
      if (clr_all) begin
        for (int i = 0; i < nr; i++) begin
          cnt_q[i] <= '0;
        end
        retire_cnt_q <= '0;
      end else if (viol.valid) begin
        for (int i = 0; i < nr; i++) begin
          if (viol.rule[i] && (cnt_q[i] != '1)) begin
            cnt_q[i] <= cnt_q[i] + 1'b1;
          end
        end
        if (retire_cnt_q != '1) begin
          retire_cnt_q <= retire_cnt_q + 1'b1;
        end
      end
    end
  end

  // Write channel, one transaction at a time
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_rdy_q  <= 1'b0;
      wr_pend_q <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      wr_pend_q <= wr_hs;
      if (wr_pend_q) begin
        b_valid_q <= 1'b1;
      end else if (axil_req.b_ready) begin
        b_valid_q <= 1'b0;
      end
      wr_rdy_q <= !(wr_hs || wr_pend_q || (b_valid_q && !axil_req.b_ready));
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_hs) begin
      wr_addr_q <= axil_req.aw_addr;
      wr_data_q <= axil_req.w_data;
      wr_strb_q <= axil_req.w_strb;
    end
    if (wr_pend_q) begin
      b_resp_q <= addr_ok(wr_addr_q) ? resp_okay : resp_slverr;
    end
  end

  always_comb begin
    rd_data = '0;
    case (axil_req.ar_addr[7:2])
      6'h08:   rd_data = 32'(retire_cnt_q);
      6'h09:   rd_data = 32'(status_q);
      // Control reads as zero, the clear bit does not hold
      6'h0a:   rd_data = '0;
      default: begin
        if (axil_req.ar_addr[7:2] < 6'h08) begin
          rd_data = 32'(cnt_q[axil_req.ar_addr[4:2]]);
        end
      end
    endcase
    if (!addr_ok(axil_req.ar_addr)) begin
      rd_data = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_rdy_q  <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (rd_hs) begin
        r_valid_q <= 1'b1;
      end else if (axil_req.r_ready) begin
        r_valid_q <= 1'b0;
      end
      rd_rdy_q <= !(rd_hs || (r_valid_q && !axil_req.r_ready));
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_hs) begin
      r_data_q <= rd_data;
      r_resp_q <= addr_ok(axil_req.ar_addr) ? resp_okay : resp_slverr;
    end
  end

  always_comb begin
    axil_rsp          = '0;
    axil_rsp.aw_ready = wr_rdy_q;
    axil_rsp.w_ready  = wr_rdy_q;
    axil_rsp.b_valid  = b_valid_q;
    axil_rsp.b_resp   = b_resp_q;
    axil_rsp.ar_ready = rd_rdy_q;
    axil_rsp.r_valid  = r_valid_q;
    axil_rsp.r_data   = r_data_q;
    axil_rsp.r_resp   = r_resp_q;
  end

  a_r_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    axil_rsp.r_valid && !axil_req.r_ready |=> axil_rsp.r_valid && $stable(axil_rsp.r_data)
  );

  a_b_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    axil_rsp.b_valid && !axil_req.b_ready |=> axil_rsp.b_valid && $stable(axil_rsp.b_resp)
  );

endmodule

// File: rvfi_monitor_top.sv
module rvfi_monitor_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  rvfi_pkg::retire_t  retire,
  input  logic               bus_valid,
  input  logic               bus_ready,
  input  mon_pkg::axil_req_t axil_req,
  output mon_pkg::axil_rsp_t axil_rsp
);

  mon_pkg::dec_t  dec;
  mon_pkg::viol_t viol;

  // Record decode, one cycle
  rvfi_decode u_decode (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .retire (retire),
    .dec    (dec)
  );

  // Rule evaluation and bus accounting, one cycle
  rvfi_rule_check u_rule_check (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .dec       (dec),
    .bus_valid (bus_valid),
    .bus_ready (bus_ready),
    .viol      (viol)
  );

  mon_result_regs u_result_regs (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .viol     (viol),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
  );

endmodule

// File: tb_rvfi_monitor.sv
module tb_rvfi_monitor;

  localparam int num_records = 28;
  localparam int num_cols    = 11;
  localparam int period      = 8;
  localparam int limit       = (num_records * 8 + 400) * period;

  logic               clk_i;
  logic               rst_ni;
  rvfi_pkg::retire_t  retire;
  logic               bus_valid;
  logic               bus_ready;
  mon_pkg::axil_req_t axil_req;
  mon_pkg::axil_rsp_t axil_rsp;

  logic [31:0] golden [num_records*num_cols];
  logic [31:0] lcg_state;
  logic [31:0] rd_data;
  logic [1:0]  rd_resp;
  logic [1:0]  wr_resp;
  logic [7:0]  exp_status;
  int          exp_cnt [8];
  int          checks;
  int          errors;
  int          test_errors;
  int          tests_run;
  int          tests_ok;
  int          n_clean;

  rvfi_monitor_top uut (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .retire    (retire),
    .bus_valid (bus_valid),
    .bus_ready (bus_ready),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp)
  );

  initial clk_i = 1'b0;
  always #(period / 2) clk_i = ~clk_i;

  function automatic logic [1:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[17:16];
  endfunction

  // Builds one retirement record from a golden line
  function automatic rvfi_pkg::retire_t make_record(int idx);
    rvfi_pkg::retire_t r;
    logic [31:0]       f;
    int                b;
    b = idx * num_cols;
    f = golden[b];
    r = '0;
    r.valid                 = 1'b1;
    r.rs1_addr              = golden[b+1][4:0];
    r.rs1_rdata             = golden[b+2];
    r.dbg                   = golden[b+3][2:0];
    r.dcsr_rdata            = golden[b+4];
    r.dbg_mode              = f[0];
    r.trap.trap             = f[1];
    r.trap.exception        = f[2];
    r.trap.exception_cause  = golden[b+5][10:0];
    r.intr.intr             = f[3];
    r.intr.exception        = f[4];
    r.intr.interrupt        = f[5];
    r.intr.cause            = golden[b+5][10:0];
    r.mcause_wdata          = golden[b+6];
    r.mcause_wmask          = golden[b+7];
    r.mem_rmask             = golden[b+8][3:0];
    r.mem_wmask             = golden[b+8][7:4];
    r.is_load               = f[6];
    r.is_store              = f[7];
    return r;
  endfunction

  task automatic tick();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_eq(string what, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at time %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic begin_test();
    test_errors = errors;
  endtask

  task automatic end_test(string name);
    tests_run++;
    if (errors == test_errors) begin
      tests_ok++;
      $display("[%s] ok", name);
    end else begin
      $display("[%s] FAIL with %0d errors", name, errors - test_errors);
    end
  endtask

  task automatic apply_reset();
    retire    = '0;
    bus_valid = 1'b0;
    bus_ready = 1'b0;
    axil_req  = '0;
    rst_ni    = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
  endtask

  task automatic read_reg(logic [7:0] addr, int delay, output logic [31:0] data,
                          output logic [1:0] resp);
    axil_req.ar_addr  = addr;
    axil_req.ar_valid = 1'b1;
    while (!axil_rsp.ar_ready) tick();
    tick();
    axil_req.ar_valid = 1'b0;
    // Hold off rready to exercise back-pressure
    repeat (delay) tick();
    axil_req.r_ready = 1'b1;
    while (!axil_rsp.r_valid) tick();
    data = axil_rsp.r_data;
    resp = axil_rsp.r_resp;
    tick();
    axil_req.r_ready = 1'b0;
  endtask

  task automatic write_reg(logic [7:0] addr, logic [31:0] data, int delay,
                           output logic [1:0] resp);
    axil_req.aw_addr  = addr;
    axil_req.aw_valid = 1'b1;
    axil_req.w_data   = data;
    axil_req.w_strb   = 4'hf;
    axil_req.w_valid  = 1'b1;
    while (!(axil_rsp.aw_ready && axil_rsp.w_ready)) tick();
    tick();
    axil_req.aw_valid = 1'b0;
    axil_req.w_valid  = 1'b0;
    repeat (delay) tick();
    axil_req.b_ready = 1'b1;
    while (!axil_rsp.b_valid) tick();
    resp = axil_rsp.b_resp;
    tick();
    axil_req.b_ready = 1'b0;
  endtask

  task automatic expect_read(logic [7:0] addr, logic [31:0] exp);
    logic [31:0] data;
    logic [1:0]  resp;
    int          delay;
    delay = int'(next_rand());
    read_reg(addr, delay, data, resp);
    check_eq($sformatf("read 0x%02h", addr), data, exp);
    check_eq($sformatf("read 0x%02h resp", addr), 32'(resp), 32'd0);
  endtask

  task automatic expect_write(logic [7:0] addr, logic [31:0] data);
    logic [1:0] resp;
    int         delay;
    delay = int'(next_rand());
    write_reg(addr, data, delay, resp);
    check_eq($sformatf("write 0x%02h resp", addr), 32'(resp), 32'd0);
  endtask

  // Bus beats go out only after the previous record has left rule check
  task automatic replay(int first, int last);
    int gap;
    int beats;
    for (int i = first; i < last; i++) begin
      gap   = int'(next_rand());
      beats = int'(golden[i*num_cols+9]);
      if (beats != 0 && gap == 0) begin
        gap = 1;
      end
      repeat (gap) tick();
      repeat (beats) begin
        bus_valid = 1'b1;
        bus_ready = 1'b1;
        tick();
      end
      bus_valid = 1'b0;
      bus_ready = 1'b0;
      retire = make_record(i);
      tick();
      retire = '0;
    end
    // Counters reflect a record three edges after it is taken
    repeat (4) tick();
  endtask

  initial begin
    #(limit);
    $display("Timeout: the run did not finish within %0d time units", limit);
    $display("test failed");
    $finish;
  end

  initial begin
    lcg_state   = 32'd6;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    tests_run   = 0;
    tests_ok    = 0;
    exp_status  = '0;
    $readmemh("rvfi_golden.txt", golden);

    // Leading records with no expected bit form the clean set
    n_clean = 0;
    while (n_clean < num_records && golden[n_clean*num_cols+10] == 32'd0) begin
      n_clean++;
    end
    for (int r = 0; r < 8; r++) begin
      exp_cnt[r] = 0;
    end
    for (int i = n_clean; i < num_records; i++) begin
      for (int r = 0; r < 8; r++) begin
        exp_cnt[r] += int'(golden[i*num_cols+10][r]);
      end
      exp_status |= golden[i*num_cols+10][7:0];
    end

    apply_reset();

    begin_test();
    repeat (2) tick();
    check_eq("bvalid before any request", 32'(axil_rsp.b_valid), 32'd0);
    check_eq("rvalid before any request", 32'(axil_rsp.r_valid), 32'd0);
    for (int a = 0; a <= 'h28; a += 4) begin
      expect_read(8'(a), 32'd0);
    end
    end_test("reset values");

    begin_test();
    replay(0, n_clean);
    for (int r = 0; r < 8; r++) begin
      expect_read(8'(r * 4), 32'd0);
    end
    expect_read(8'h20, 32'(n_clean));
    expect_read(8'h24, 32'd0);
    end_test("clean records");

    // Fresh reset so the first violating record is the first retirement
    apply_reset();
    begin_test();
    fork
      replay(n_clean, num_records);
      repeat (4) begin
        read_reg(8'h20, 3, rd_data, rd_resp);
        check_eq("retire read under back-pressure resp", 32'(rd_resp), 32'd0);
        // Zero data clears no status bit
        write_reg(8'h24, 32'd0, 3, wr_resp);
        check_eq("status write under back-pressure resp", 32'(wr_resp), 32'd0);
      end
    join
    for (int r = 0; r < 8; r++) begin
      if (r != 4 && r != 7) begin
        expect_read(8'(r * 4), 32'(exp_cnt[r]));
      end
    end
    expect_read(8'h20, 32'(num_records - n_clean));
    expect_read(8'h24, 32'(exp_status));
    end_test("rule counters");

    begin_test();
    expect_read(8'h10, 32'(exp_cnt[4]));
    end_test("interrupt cause legality");

    begin_test();
    expect_read(8'h1c, 32'(exp_cnt[7]));
    end_test("memory over-report");

    begin_test();
    expect_write(8'h24, 32'h2);
    expect_read(8'h24, 32'(exp_status & 8'hfd));
    expect_write(8'h28, 32'h1);
    for (int a = 0; a <= 'h20; a += 4) begin
      expect_read(8'(a), 32'd0);
    end
    read_reg(8'h40, int'(next_rand()), rd_data, rd_resp);
    check_eq("read 0x40 data", rd_data, 32'd0);
    check_eq("read 0x40 resp", 32'(rd_resp), 32'd2);
    end_test("clear and decode");

    $display("Checks run: %0d, errors: %0d, tests ok: %0d of %0d",
             checks, errors, tests_ok, tests_run);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+.
rvfi_pkg.sv
mon_pkg.sv
rvfi_decode.sv
rvfi_rule_check.sv
mon_result_regs.sv
rvfi_monitor_top.sv
tb_rvfi_monitor.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f \
  --top-module tb_rvfi_monitor -o tb_rvfi_monitor

# The simulator status is not trusted, the log decides
./obj_dir/tb_rvfi_monitor > sim.log 2>&1 || true
cat sim.log

grep -qx "test passed" sim.log

// File: rvfi_golden.txt
// flags rs1_addr rs1_rdata dbg dcsr cause mcause_wdata mcause_wmask masks beats expected
// flags: 0 dbg_mode 1 trap 2 exc 3 intr 4 intr_exc 5 intr_irq 6 load 7 store; masks: wmask rmask
00 05 00000000 0 00000000 000 00000000 00000000 00 0 00
40 02 00001000 0 00000000 000 00000000 00000000 0F 1 00
80 02 00001000 0 00000000 000 00000000 00000000 F0 1 00
06 00 00000000 0 00000000 002 00000002 800007FF 00 0 00
28 00 00000000 0 00000000 00B 00000000 00000000 00 0 00
28 00 00000000 0 00000000 014 00000000 00000000 00 0 00
28 00 00000000 0 00000000 401 00000000 00000000 00 0 00
01 00 00000000 3 000000C0 000 00000000 00000000 00 0 00
07 00 00000000 0 00000000 005 00000000 00000000 00 0 00
42 00 00000000 0 00000000 000 00000000 00000000 00 0 00
C0 00 00000000 0 00000000 000 00000000 00000000 FF 2 00
00 01 DEADBEEF 0 00000000 000 00000000 00000000 00 0 01
01 00 00000000 2 000000C0 000 00000000 00000000 00 0 02
00 00 00000000 0 00000000 000 00000000 00000000 00 0 00
01 00 00000000 1 00000040 000 00000000 00000000 00 0 00
01 00 00000000 4 00000040 000 00000000 00000000 00 0 00
06 00 00000000 0 00000000 007 00000005 800007FF 00 0 04
06 00 00000000 0 00000000 00D 8000000D 800007FF 00 0 08
06 00 00000000 0 00000000 001 00000001 000007FF 00 0 08
06 00 00000000 0 00000000 003 0000000F 80000003 00 0 00
28 00 00000000 0 00000000 005 00000000 00000000 00 0 10
28 00 00000000 0 00000000 028 00000000 00000000 00 0 10
38 00 00000000 0 00000000 00B 00000000 00000000 00 0 20
00 00 00000000 0 00000000 000 00000000 00000000 03 1 40
80 00 00000000 0 00000000 000 00000000 00000000 00 0 40
40 00 00000000 0 00000000 000 00000000 00000000 0F 0 80
80 00 00000000 0 00000000 000 00000000 00000000 F0 2 00
C0 00 00000000 0 00000000 000 00000000 00000000 FF 1 80
